// ==== testbench/datapath_vectors.txt ====
// Header: program words, data pairs, expected stores
// Then program words, data pairs (addr value), stores (test addr value)
0000004E 00000002 0000001F
24010005 2402FFFD 34038001 3C041234 240A0100 00222821 00223023 00433824
00644025 0041482A 0022582A AD410000 AD420004 AD430008 AD44000C AD450010
AD460014 AD470018 AD48001C AD490020 AD4B0024 8D4C0080 8D4D0084 00000000
00000000 258C0101 01A17025 00000000 00000000 AD4C0080 AD4E0084 8D4F0080
24100007 24110007 24120009 AD4F0088 00000000 00000000 12110003 AD410040
AD410044 AD40007C AD450048 12120003 AD46004C AD460050 AD490054 16120003
AD470058 AD47005C AD40007C 16110003 AD480060 00000000 AD490064 0800003B
AD410068 AD45006C AD40007C 0C000048 AD460070 00000000 AD490074 FC000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 AD5F0078 03E00008 AD450090 AD460094 AD40007C
00000180 00001234 00000184 FFFF0000
00000001 00000100 00000005  00000001 00000104 FFFFFFFD
00000001 00000108 00008001  00000001 0000010C 12340000
00000001 00000110 00000002  00000001 00000114 00000008
00000001 00000118 00008001  00000001 0000011C 12348001
00000001 00000120 00000001  00000001 00000124 00000000
00000002 00000180 00001335  00000002 00000184 FFFF0005
00000002 00000188 00001335
00000003 00000140 00000005  00000003 00000144 00000005
00000003 00000148 00000002  00000003 0000014C 00000008
00000003 00000150 00000008  00000003 00000154 00000001
00000003 00000158 00008001  00000003 0000015C 00008001
00000003 00000160 12348001  00000003 00000164 00000001
00000003 00000168 00000005  00000003 0000016C 00000002
00000003 00000170 00000008  00000003 00000178 000000F0
00000003 00000190 00000002  00000003 00000194 00000008
00000003 00000170 00000008  00000003 00000174 00000001

// ==== list.f ====
hdl/cpu_types_pkg.sv
hdl/fetch_stage.sv
hdl/pipeline_latch.sv
hdl/control_unit.sv
hdl/register_file.sv
hdl/alu.sv
hdl/datapath.sv
testbench/cache_model.sv
testbench/datapath_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module datapath_tb -f list.f -o datapath_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/datapath_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^sim passed$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== testbench/datapath_tb.sv ====
`timescale 1ns/1ps

module datapath_tb;

  localparam cpu_types_pkg::word_t PC_INIT = 32'h0000_0000;

  logic                 CLK;
  logic                 nRST;
  cpu_types_pkg::word_t imemaddr, imemload;
  cpu_types_pkg::word_t dmemaddr, dmemstore, dmemload;
  logic                 imemren, ihit, dmemren, dmemwen, dhit, halt;
  logic                 xfer;
  logic [31:0]          vec [256];
  int                   prog_len, data_cnt, store_cnt, base;
  int                   seen, stall_cycles, limit_cycles;

  datapath #(.PC_INIT(PC_INIT)) UUT (
    .CLK(CLK), .nRST(nRST),
    .imemaddr(imemaddr), .imemren(imemren), .imemload(imemload), .ihit(ihit),
    .dmemaddr(dmemaddr), .dmemstore(dmemstore), .dmemren(dmemren),
    .dmemwen(dmemwen), .dmemload(dmemload), .dhit(dhit), .halt(halt)
  );

  cache_model mem_model (
    .CLK(CLK),
    .imemaddr(imemaddr), .imemren(imemren), .imemload(imemload), .ihit(ihit),
    .dmemaddr(dmemaddr), .dmemstore(dmemstore), .dmemren(dmemren),
    .dmemwen(dmemwen), .dmemload(dmemload), .dhit(dhit), .xfer(xfer)
  );

  // Test id column of the store table
  function automatic string test_name(input logic [31:0] id);
    case (id)
      32'd1:   return "alu_ops";
      32'd2:   return "load_store";
      32'd3:   return "control_flow";
      default: return "unknown";
    endcase
  endfunction

  task automatic fail_run();
    $display("sim failed");
    $fatal(1, "run stopped at the first error");
  endtask

  // Outputs while nRST is held low
  task automatic verify_reset_state();
    assert (imemaddr == PC_INIT) else begin
      $display("ERROR reset: expected imemaddr %h, actual %h", PC_INIT, imemaddr);
      fail_run();
    end
    assert ({imemren, dmemren, dmemwen, halt} == 4'b1000) else begin
      $display("ERROR reset: expected imemren dmemren dmemwen halt 1000, actual %b%b%b%b",
               imemren, dmemren, dmemwen, halt);
      fail_run();
    end
  endtask

  // Compare one completed store with the next table entry
  task automatic check_store();
    int    idx;
    string name;
    idx = base + 3 * seen;
    assert (seen < store_cnt) else begin
      $display("Store to %h after all expected stores were seen", dmemaddr);
      fail_run();
    end
    name = test_name(vec[idx]);
    assert (dmemaddr == vec[idx + 1]) else begin
      $display("ERROR %s: expected addr %h, actual %h", name, vec[idx + 1], dmemaddr);
      fail_run();
    end
    assert (dmemstore == vec[idx + 2]) else begin
      $display("ERROR %s: expected data %h, actual %h", name, vec[idx + 2], dmemstore);
      fail_run();
    end
    seen = seen + 1;
  endtask

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // Store and stall monitor, sampled mid-cycle
  always @(negedge CLK) begin
    if (nRST && halt) begin
      // Nothing may be written once halted
      assert (!dmemwen) else begin
        $display("ERROR halt: expected no store, actual store to %h", dmemaddr);
        fail_run();
      end
    end
    if (nRST && xfer && dmemwen) begin
      check_store();
    end
    if (nRST && !halt && !xfer) begin
      stall_cycles = stall_cycles + 1;
    end
  end

  initial begin
    nRST         = 1'b0;
    seen         = 0;
    stall_cycles = 0;
    $readmemh("testbench/datapath_vectors.txt", vec);
    prog_len  = int'(vec[0]);
    data_cnt  = int'(vec[1]);
    store_cnt = int'(vec[2]);
    // Store table follows program and data pairs
    base = 3 + prog_len + 2 * data_cnt;
    repeat (8) @(posedge CLK);
    verify_reset_state();
    #10 nRST = 1'b1;
    wait (halt === 1'b1);
    // Window to catch any late store
    repeat (10) @(posedge CLK);
    assert (seen == store_cnt) else begin
      $display("ERROR halt: expected %0d stores, actual %0d", store_cnt, seen);
      fail_run();
    end
    assert (stall_cycles > 0) else begin
      $display("stall_hold: the random hit delays never stalled the pipeline");
      fail_run();
    end
    $display("sim passed");
    $finish;
  end

  // Watchdog, 8 cycles per program word plus 4 per advance at worst hit delay
  initial begin
    #1;
    limit_cycles = 8 * prog_len + 4 * (prog_len + 16) + 8;
    repeat (limit_cycles) @(posedge CLK);
    $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
    fail_run();
  end

endmodule

// ==== testbench/cache_model.sv ====
`timescale 1ns/1ps

module cache_model (
  input  logic                 CLK,
  input  cpu_types_pkg::word_t imemaddr,
  input  logic                 imemren,
  output cpu_types_pkg::word_t imemload,
  output logic                 ihit,
  input  cpu_types_pkg::word_t dmemaddr,
  input  cpu_types_pkg::word_t dmemstore,
  input  logic                 dmemren,
  input  logic                 dmemwen,
  output cpu_types_pkg::word_t dmemload,
  output logic                 dhit,
  output logic                 xfer
);

  logic [31:0] vec  [256];
  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [15:0] lfsr;
  logic [1:0]  iwait, dwait, icnt, dcnt;
  logic        xfer_seen;
  int          prog_len, data_cnt;

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // Two bits, one step each
  task automatic draw_wait(output logic [1:0] w);
    lfsr = lfsr_step(lfsr);
    w[0] = lfsr[0];
    lfsr = lfsr_step(lfsr);
    w[1] = lfsr[0];
  endtask

  // Pipeline moves at an edge where this is high
  assign xfer = ihit && (!(dmemren || dmemwen) || dhit);

  initial begin
    lfsr     = 16'd36460;
    ihit     = 1'b0;
    dhit     = 1'b0;
    imemload = '0;
    dmemload = '0;
    $readmemh("testbench/datapath_vectors.txt", vec);
    prog_len = int'(vec[0]);
    data_cnt = int'(vec[1]);
    for (int i = 0; i < 256; i++) begin
      imem[i] = '0;
      // Unwritten data words carry their own address
      dmem[i] = 32'hA5A50000 ^ (i * 4);
    end
    for (int i = 0; i < prog_len; i++) begin
      imem[i] = vec[3 + i];
    end
    for (int i = 0; i < data_cnt; i++) begin
      dmem[vec[3 + prog_len + 2 * i][9:2]] = vec[4 + prog_len + 2 * i];
    end
    draw_wait(iwait);
    draw_wait(dwait);
    icnt = '0;
    dcnt = '0;
    forever begin
      // Settled values between edges
      @(negedge CLK);
      xfer_seen = xfer;
      if (xfer_seen && dmemwen) begin
        dmem[dmemaddr[9:2]] = dmemstore;
      end
      @(posedge CLK);
      #10;
      if (xfer_seen) begin
        // Fresh delays for the next requests
        icnt = '0;
        dcnt = '0;
        draw_wait(iwait);
        draw_wait(dwait);
      end else begin
        if (icnt != iwait) begin
          icnt = icnt + 2'd1;
        end
        if ((dmemren || dmemwen) && dcnt != dwait) begin
          dcnt = dcnt + 2'd1;
        end
      end
      ihit     = imemren && (icnt == iwait);
      dhit     = (dmemren || dmemwen) && (dcnt == dwait);
      imemload = imem[imemaddr[9:2]];
      dmemload = dmemren ? dmem[dmemaddr[9:2]] : '0;
    end
  end

endmodule

// ==== hdl/datapath.sv ====
`timescale 1ns/1ps

module datapath #(
  parameter cpu_types_pkg::word_t PC_INIT = '0
) (
  input  logic                 CLK,
  input  logic                 nRST,
  // Instruction side
  output cpu_types_pkg::word_t imemaddr,
  output logic                 imemren,
  input  cpu_types_pkg::word_t imemload,
  input  logic                 ihit,
  // Data side
  output cpu_types_pkg::word_t dmemaddr,
  output cpu_types_pkg::word_t dmemstore,
  output logic                 dmemren,
  output logic                 dmemwen,
  input  cpu_types_pkg::word_t dmemload,
  input  logic                 dhit,
  output logic                 halt
);

  logic                    advance;
  cpu_types_pkg::fd_t      fd_d, fd_q;
  cpu_types_pkg::de_t      de_d, de_q;
  cpu_types_pkg::em_t      em_d, em_q;
  cpu_types_pkg::mw_t      mw_d, mw_q;
  cpu_types_pkg::word_t    fetch_npc;
  cpu_types_pkg::ctrl_t    ctrl;
  cpu_types_pkg::opcode_t  opcode;
  cpu_types_pkg::funct_t   funct;
  cpu_types_pkg::regbits_t rs, rt, rd;
  logic [15:0]             imm;
  cpu_types_pkg::word_t    imm_ext;
  cpu_types_pkg::word_t    rdat1, rdat2;
  cpu_types_pkg::word_t    alu_b, alu_out;
  logic                    alu_zero;
  logic                    branch_taken;
  cpu_types_pkg::word_t    branch_target;
  logic                    rf_wen;
  cpu_types_pkg::word_t    rf_wdat;

  // Fetch
  fetch_stage #(.PC_INIT(PC_INIT)) fetch (
    .CLK(CLK), .nRST(nRST), .advance(advance), .jumpsel(de_q.jumpsel),
    .branch_taken(branch_taken), .branch_target(branch_target),
    .jump_target(de_q.jumpaddr), .reg_target(de_q.port_a),
    .imemaddr(imemaddr), .npc(fetch_npc)
  );
  // Keep requesting until halted
  assign imemren = ~halt;
  assign fd_d = '{instr: imemload, npc: fetch_npc};

  // Stage latches, flush left unused for now
  pipeline_latch #(.latch_t(cpu_types_pkg::fd_t)) fd (
    .CLK(CLK), .nRST(nRST), .advance(advance), .flush(1'b0), .d(fd_d), .q(fd_q));
  pipeline_latch #(.latch_t(cpu_types_pkg::de_t)) de (
    .CLK(CLK), .nRST(nRST), .advance(advance), .flush(1'b0), .d(de_d), .q(de_q));
  pipeline_latch #(.latch_t(cpu_types_pkg::em_t)) em (
    .CLK(CLK), .nRST(nRST), .advance(advance), .flush(1'b0), .d(em_d), .q(em_q));
  pipeline_latch #(.latch_t(cpu_types_pkg::mw_t)) mw (
    .CLK(CLK), .nRST(nRST), .advance(advance), .flush(1'b0), .d(mw_d), .q(mw_q));

  // Decode, instruction fields
  assign opcode  = cpu_types_pkg::opcode_t'(fd_q.instr[31:26]);
  assign rs      = fd_q.instr[25:21];
  assign rt      = fd_q.instr[20:16];
  assign rd      = fd_q.instr[15:11];
  assign imm     = fd_q.instr[15:0];
  assign funct   = cpu_types_pkg::funct_t'(fd_q.instr[5:0]);
  assign imm_ext = ctrl.extop ? {{16{imm[15]}}, imm} : {16'h0000, imm};

  control_unit ctrl_dec (.opcode(opcode), .funct(funct), .ctrl(ctrl));

  register_file regs (
    .CLK(CLK), .nRST(nRST), .wen(rf_wen), .wsel(mw_q.rw), .wdat(rf_wdat),
    .rsel1(rs), .rsel2(rt), .rdat1(rdat1), .rdat2(rdat2)
  );

  always_comb begin
    de_d.aluop    = ctrl.aluop;
    de_d.alusrc   = ctrl.alusrc;
    de_d.beq      = ctrl.beq;
    de_d.bne      = ctrl.bne;
    de_d.jumpsel  = ctrl.jumpsel;
    // Region bits come from the delay-slot address
    de_d.jumpaddr = {fd_q.npc[31:28], fd_q.instr[25:0], 2'b00};
    de_d.dren     = ctrl.dren;
    de_d.dwen     = ctrl.dwen;
    // JAL links r31, R-type writes rd, the rest rt
    de_d.rw       = ctrl.jal ? 5'd31 : (ctrl.regdst ? rd : rt);
    de_d.regwr    = ctrl.regwr;
    de_d.memtoreg = ctrl.memtoreg;
    de_d.halt     = ctrl.halt;
    de_d.npc      = fd_q.npc;
    de_d.port_a   = rdat1;
    de_d.port_b   = rdat2;
    de_d.imm_ext  = imm_ext;
  end

  // Execute
  assign alu_b = de_q.alusrc ? de_q.imm_ext : de_q.port_b;

  alu ex_alu (
    .aluop(de_q.aluop), .porta(de_q.port_a), .portb(alu_b),
    .oport(alu_out), .zero(alu_zero)
  );

  // Resolved here, the two younger words run as delay slots
  assign branch_taken  = (de_q.beq & alu_zero) | (de_q.bne & ~alu_zero);
  assign branch_target = de_q.npc + {de_q.imm_ext[29:0], 2'b00};

  assign em_d = '{dren: de_q.dren, dwen: de_q.dwen, rw: de_q.rw, regwr: de_q.regwr,
                  memtoreg: de_q.memtoreg, halt: de_q.halt, npc: de_q.npc,
                  port_o: alu_out, lui: {de_q.imm_ext[15:0], 16'h0000},
                  dmemstore: de_q.port_b};

  // Memory, requests held until the hit
  assign dmemaddr  = em_q.port_o;
  assign dmemstore = em_q.dmemstore;
  assign dmemren   = em_q.dren & ~halt;
  assign dmemwen   = em_q.dwen & ~halt;

  // Single stall condition for every stage
  assign advance = ihit & (~(dmemren | dmemwen) | dhit);

  assign mw_d = '{rw: em_q.rw, regwr: em_q.regwr, memtoreg: em_q.memtoreg,
                  halt: em_q.halt, npc: em_q.npc, port_o: em_q.port_o,
                  lui: em_q.lui, dmemload: dmemload};

  // Write-back
  assign rf_wen = mw_q.regwr & advance;

  always_comb begin
    case (mw_q.memtoreg)
      cpu_types_pkg::WB_NPC:  rf_wdat = mw_q.npc;
      cpu_types_pkg::WB_LOAD: rf_wdat = mw_q.dmemload;
      cpu_types_pkg::WB_LUI:  rf_wdat = mw_q.lui;
      default:                rf_wdat = mw_q.port_o;
    endcase
  end

  // Sticky halt once HALT sits in the last latch
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (mw_q.halt) begin
      halt <= 1'b1;
    end
  end

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  cpu_types_pkg::aluop_t aluop,
  input  cpu_types_pkg::word_t  porta,
  input  cpu_types_pkg::word_t  portb,
  output cpu_types_pkg::word_t  oport,
  output logic                  zero
);

  always_comb begin
    case (aluop)
      cpu_types_pkg::ALU_ADD: oport = porta + portb;
      cpu_types_pkg::ALU_SUB: oport = porta - portb;
      cpu_types_pkg::ALU_AND: oport = porta & portb;
      cpu_types_pkg::ALU_OR:  oport = porta | portb;
      // Signed compare, result in bit 0
      cpu_types_pkg::ALU_SLT: oport = {31'b0, $signed(porta) < $signed(portb)};
      // Upper half from the immediate
      cpu_types_pkg::ALU_LUI: oport = {portb[15:0], 16'h0000};
      default:                oport = '0;
    endcase
  end

  // Branch compare uses this
  assign zero = (oport == '0);

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps

module register_file (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    wen,
  input  cpu_types_pkg::regbits_t wsel,
  input  cpu_types_pkg::word_t    wdat,
  input  cpu_types_pkg::regbits_t rsel1,
  input  cpu_types_pkg::regbits_t rsel2,
  output cpu_types_pkg::word_t    rdat1,
  output cpu_types_pkg::word_t    rdat2
);

  cpu_types_pkg::word_t regs [32];

  // Register 0 is never written
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      regs <= '{default: '0};
    end else if (wen && wsel != '0) begin
      regs[wsel] <= wdat;
    end
  end

  // Asynchronous read ports
  assign rdat1 = regs[rsel1];
  assign rdat2 = regs[rsel2];

  // Register 0 reads zero on both ports
  assert property (@(posedge CLK) disable iff (!nRST)
    (rsel1 != '0 || rdat1 == '0) && (rsel2 != '0 || rdat2 == '0));

endmodule

// ==== hdl/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
  input  cpu_types_pkg::opcode_t opcode,
  input  cpu_types_pkg::funct_t  funct,
  output cpu_types_pkg::ctrl_t   ctrl
);

  always_comb begin
    // Safe defaults, unknown words act as NOPs
    ctrl          = '0;
    ctrl.aluop    = cpu_types_pkg::ALU_ADD;
    ctrl.jumpsel  = cpu_types_pkg::SEL_BRANCH;
    ctrl.memtoreg = cpu_types_pkg::WB_ALU;

    case (opcode)
      cpu_types_pkg::RTYPE: begin
        // Register-register ops write rd
        ctrl.regdst = 1'b1;
        ctrl.regwr  = 1'b1;
        case (funct)
          cpu_types_pkg::ADDU: ctrl.aluop = cpu_types_pkg::ALU_ADD;
          cpu_types_pkg::SUBU: ctrl.aluop = cpu_types_pkg::ALU_SUB;
          cpu_types_pkg::AND:  ctrl.aluop = cpu_types_pkg::ALU_AND;
          cpu_types_pkg::OR:   ctrl.aluop = cpu_types_pkg::ALU_OR;
          cpu_types_pkg::SLT:  ctrl.aluop = cpu_types_pkg::ALU_SLT;
          cpu_types_pkg::JR: begin
            ctrl.regwr   = 1'b0;
            ctrl.jumpsel = cpu_types_pkg::SEL_REG;
          end
          // Includes the all-zero NOP word
          default: ctrl.regwr = 1'b0;
        endcase
      end
      cpu_types_pkg::ADDIU: begin
        ctrl.alusrc = 1'b1;
        ctrl.extop  = 1'b1;
        ctrl.regwr  = 1'b1;
      end
      cpu_types_pkg::ORI: begin
        // Zero extended immediate
        ctrl.aluop  = cpu_types_pkg::ALU_OR;
        ctrl.alusrc = 1'b1;
        ctrl.regwr  = 1'b1;
      end
      cpu_types_pkg::LUI: begin
        ctrl.aluop    = cpu_types_pkg::ALU_LUI;
        ctrl.alusrc   = 1'b1;
        ctrl.regwr    = 1'b1;
        ctrl.memtoreg = cpu_types_pkg::WB_LUI;
      end
      cpu_types_pkg::LW: begin
        ctrl.alusrc   = 1'b1;
        ctrl.extop    = 1'b1;
        ctrl.dren     = 1'b1;
        ctrl.regwr    = 1'b1;
        ctrl.memtoreg = cpu_types_pkg::WB_LOAD;
      end
      cpu_types_pkg::SW: begin
        ctrl.alusrc = 1'b1;
        ctrl.extop  = 1'b1;
        ctrl.dwen   = 1'b1;
      end
      cpu_types_pkg::BEQ: begin
        // Compare by subtraction, offset sign extended
        ctrl.aluop = cpu_types_pkg::ALU_SUB;
        ctrl.extop = 1'b1;
        ctrl.beq   = 1'b1;
      end
      cpu_types_pkg::BNE: begin
        ctrl.aluop = cpu_types_pkg::ALU_SUB;
        ctrl.extop = 1'b1;
        ctrl.bne   = 1'b1;
      end
      cpu_types_pkg::J: ctrl.jumpsel = cpu_types_pkg::SEL_JUMP;
      cpu_types_pkg::JAL: begin
        // Link register 31 with the return address
        ctrl.jumpsel  = cpu_types_pkg::SEL_JUMP;
        ctrl.jal      = 1'b1;
        ctrl.regwr    = 1'b1;
        ctrl.memtoreg = cpu_types_pkg::WB_NPC;
      end
      cpu_types_pkg::HALT: ctrl.halt = 1'b1;
      default: ctrl.halt = 1'b0;
    endcase
  end

endmodule

// ==== hdl/pipeline_latch.sv ====
`timescale 1ns/1ps

module pipeline_latch #(
  parameter type latch_t = logic
) (
  input  logic   CLK,
  input  logic   nRST,
  input  logic   advance,
  input  logic   flush,
  input  latch_t d,
  output latch_t q
);

  // All-zero contents form a bubble
  // (no write, no memory access, no halt)
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      q <= '0;
    end else if (flush) begin
      q <= '0;
    end else if (advance) begin
      q <= d;
    end
  end

  // Flushing a frozen stage would drop a held instruction
  assert property (@(posedge CLK) disable iff (!nRST) flush |-> advance);

endmodule

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
  parameter cpu_types_pkg::word_t PC_INIT = '0
) (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    advance,
  input  cpu_types_pkg::jumpsel_t jumpsel,
  input  logic                    branch_taken,
  input  cpu_types_pkg::word_t    branch_target,
  input  cpu_types_pkg::word_t    jump_target,
  input  cpu_types_pkg::word_t    reg_target,
  output cpu_types_pkg::word_t    imemaddr,
  output cpu_types_pkg::word_t    npc
);

  cpu_types_pkg::word_t pc;
  cpu_types_pkg::word_t next_pc;

  // Sequential successor, also carried down the pipe for JAL
  assign npc      = pc + 32'd4;
  assign imemaddr = pc;

  // Control word in execute picks the target
  always_comb begin
    case (jumpsel)
      cpu_types_pkg::SEL_JUMP: next_pc = jump_target;
      cpu_types_pkg::SEL_REG:  next_pc = reg_target;
      default:                 next_pc = branch_taken ? branch_target : npc;
    endcase
  end

  // PC moves only when the whole pipe moves
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= PC_INIT;
    end else if (advance) begin
      pc <= next_pc;
    end
  end

  // Targets come from execute, so misalignment would show up here
  assert property (@(posedge CLK) disable iff (!nRST) pc[1:0] == 2'b00);

endmodule

// ==== hdl/cpu_types_pkg.sv ====
package cpu_types_pkg;

  // Data word and register index
  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;

  // Opcodes of the supported subset
  typedef enum logic [5:0] {
    RTYPE = 6'b000000,
    J     = 6'b000010,
    JAL   = 6'b000011,
    BEQ   = 6'b000100,
    BNE   = 6'b000101,
    ADDIU = 6'b001001,
    ORI   = 6'b001101,
    LUI   = 6'b001111,
    LW    = 6'b100011,
    SW    = 6'b101011,
    HALT  = 6'b111111
  } opcode_t;

  // Function field of R-type words
  typedef enum logic [5:0] {
    JR   = 6'b001000,
    ADDU = 6'b100001,
    SUBU = 6'b100011,
    AND  = 6'b100100,
    OR   = 6'b100101,
    SLT  = 6'b101010
  } funct_t;

  // ALU operations
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4,
    ALU_LUI = 3'd5
  } aluop_t;

  // Next-PC source, branch is the fall-through default
  typedef enum logic [1:0] {
    SEL_BRANCH = 2'd0,
    SEL_JUMP   = 2'd1,
    SEL_REG    = 2'd2
  } jumpsel_t;

  // Write-back data source
  typedef enum logic [1:0] {
    WB_ALU  = 2'd0,
    WB_NPC  = 2'd1,
    WB_LOAD = 2'd2,
    WB_LUI  = 2'd3
  } memtoreg_t;

  // Decoded control
  typedef struct packed {
    aluop_t    aluop;
    logic      alusrc;
    logic      extop;
    logic      beq;
    logic      bne;
    jumpsel_t  jumpsel;
    logic      dren;
    logic      dwen;
    logic      regdst;
    logic      jal;
    logic      regwr;
    memtoreg_t memtoreg;
    logic      halt;
  } ctrl_t;

  // Fetch to decode
  typedef struct packed {
    word_t instr;
    word_t npc;
  } fd_t;

  // Decode to execute
  typedef struct packed {
    aluop_t    aluop;
    logic      alusrc;
    logic      beq;
    logic      bne;
    jumpsel_t  jumpsel;
    word_t     jumpaddr;
    logic      dren;
    logic      dwen;
    regbits_t  rw;
    logic      regwr;
    memtoreg_t memtoreg;
    logic      halt;
    word_t     npc;
    word_t     port_a;
    word_t     port_b;
    word_t     imm_ext;
  } de_t;

  // Execute to memory
  typedef struct packed {
    logic      dren;
    logic      dwen;
    regbits_t  rw;
    logic      regwr;
    memtoreg_t memtoreg;
    logic      halt;
    word_t     npc;
    word_t     port_o;
    word_t     lui;
    word_t     dmemstore;
  } em_t;

  // Memory to write-back
  typedef struct packed {
    regbits_t  rw;
    logic      regwr;
    memtoreg_t memtoreg;
    logic      halt;
    word_t     npc;
    word_t     port_o;
    word_t     lui;
    word_t     dmemload;
  } mw_t;

endpackage
